// ==== design/singleCpu_params.svh ====
`ifndef SINGLECPU_PARAMS_SVH
`define SINGLECPU_PARAMS_SVH

// Data path and address width
`define XLEN 32

// Memory sizes in 32-bit words
`define IMEM_DEPTH 64
`define DMEM_DEPTH 64

`endif

// ==== design/singleCpuPkg.sv ====
`default_nettype none

package singleCpuPkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        SLT = 3'd4
    } aluOp_e;

    // Register view of the instruction word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeView_t;

    // Immediate view, fields shared by S and B formats
    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } immView_t;

    typedef union packed {
        rTypeView_t r;
        immView_t   i;
    } rvInstr_u;

endpackage

`default_nettype wire

// ==== design/ctrlIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ctrlIf;
    import singleCpuPkg::*;

    logic   regWrite;
    logic   aluSrc;   // Immediate as second ALU operand
    logic   memWrite;
    logic   memToReg; // Load data to writeback
    logic   branch;
    aluOp_e aluOp;

    modport decoder (output regWrite, aluSrc, memWrite, memToReg, branch, aluOp);
    modport alu (input aluSrc, aluOp);
    modport lsu (input memWrite, memToReg);
    modport regs (input regWrite);
    modport pc (input branch);

endinterface

`default_nettype wire

// ==== design/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "singleCpu_params.svh"

module instrDecoder (
    input  logic                  arstN,
    input  singleCpuPkg::rvInstr_u instr,
    ctrlIf.decoder                ctrl,
    output logic [`XLEN-1:0]      imm
);
    import singleCpuPkg::*;

    opcode_e opcode;
    aluOp_e  rAluOp;
    logic    opKnown;

    assign opcode = opcode_e'(instr.r.opcode);

    // R-type operation from funct3 and funct7 bit 5
    always_comb begin
        case (instr.r.funct3)
            3'b000:  rAluOp = instr.r.funct7[5] ? SUB : ADD;
            3'b010:  rAluOp = SLT;
            3'b110:  rAluOp = OR;
            3'b111:  rAluOp = AND;
            default: rAluOp = ADD;
        endcase
    end

    always_comb begin
        ctrl.regWrite = 1'b0;
        ctrl.aluSrc   = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.memToReg = 1'b0;
        ctrl.branch   = 1'b0;
        ctrl.aluOp    = ADD;
        opKnown       = 1'b1;
        if (arstN) begin // Nothing retires while the program loads
            case (opcode)
                OP: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluOp    = rAluOp;
                end
                OP_IMM: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                end
                LOAD: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                    ctrl.memToReg = 1'b1;
                end
                STORE: begin
                    ctrl.aluSrc   = 1'b1;
                    ctrl.memWrite = 1'b1;
                end
                BRANCH: begin
                    ctrl.branch = 1'b1;
                    ctrl.aluOp  = SUB; // Equal operands give zero
                end
                default: opKnown = 1'b0; // Executes as a no-op
            endcase
        end
    end

    // Sign-extended immediate in I, S or B format
    always_comb begin
        case (opcode)
            STORE:   imm = {{(`XLEN-12){instr.i.immHi[6]}}, instr.i.immHi, instr.i.immLo};
            BRANCH:  imm = {{(`XLEN-12){instr.i.immHi[6]}}, instr.i.immLo[0],
                            instr.i.immHi[5:0], instr.i.immLo[4:1], 1'b0};
            default: imm = {{(`XLEN-12){instr.i.immHi[6]}}, instr.i.immHi, instr.i.rs2};
        endcase
    end

    always_comb begin
        if (arstN) begin
            assert final (opKnown)
                else $error("instrDecoder: unknown opcode %b", instr.r.opcode);
        end
    end

endmodule

`default_nettype wire

// ==== design/pcUnit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "singleCpu_params.svh"

module pcUnit (
    input  logic             CLK,
    input  logic             arstN,
    ctrlIf.pc                ctrl,
    input  logic [`XLEN-1:0] imm,
    input  logic             zero,
    output logic [`XLEN-1:0] pc
);

    logic [`XLEN-1:0] pcPlus4;
    logic [`XLEN-1:0] pcTarget;
    logic [`XLEN-1:0] pcNext;

    assign pcPlus4  = pc + `XLEN'd4;
    assign pcTarget = pc + imm;                                  // B immediate has bit 0 clear
    assign pcNext   = (ctrl.branch && zero) ? pcTarget : pcPlus4; // Taken beq

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    // A bad branch offset would misalign the fetch
    assert property (@(posedge CLK) disable iff (!arstN) pc[1:0] == 2'b00)
        else $error("pcUnit: misaligned pc %h", pc);

endmodule

`default_nettype wire

// ==== design/instrMem.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "singleCpu_params.svh"

module instrMem (
    input  logic                  CLK,
    input  logic                  progWe,
    input  logic [5:0]            progAddr,
    input  logic [31:0]           progData,
    input  logic [`XLEN-1:0]      pc,
    output singleCpuPkg::rvInstr_u instr
);

    localparam int AW = $clog2(`IMEM_DEPTH);

    logic [31:0]      mem [`IMEM_DEPTH];
    logic [`XLEN-1:0] wordIdx;

    assign wordIdx = pc >> 2;

    // Program load port
    always_ff @(posedge CLK) begin
        if (progWe) begin
            mem[progAddr] <= progData;
        end
    end

    assign instr = mem[wordIdx[AW-1:0]]; // Combinational fetch

    assert property (@(posedge CLK) wordIdx < `IMEM_DEPTH)
        else $error("instrMem: fetch beyond program store, pc %h", pc);

endmodule

`default_nettype wire

// ==== design/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "singleCpu_params.svh"

module regFile (
    input  logic             CLK,
    input  logic             arstN,
    ctrlIf.regs              ctrl,
    input  logic [4:0]       rs1,
    input  logic [4:0]       rs2,
    input  logic [4:0]       rd,
    input  logic [`XLEN-1:0] wdata,
    output logic [`XLEN-1:0] rdata1,
    output logic [`XLEN-1:0] rdata2,
    output logic             wbEn
);

    logic [`XLEN-1:0] regBank [32];

    assign wbEn = ctrl.regWrite && (rd != 5'd0); // x0 never written

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regBank[i] <= '0;
            end
        end else if (wbEn) begin
            regBank[rd] <= wdata;
        end
    end

    assign rdata1 = regBank[rs1];
    assign rdata2 = regBank[rs2];

    assert property (@(posedge CLK) disable iff (!arstN)
        ((rs1 == 5'd0) -> (rdata1 == '0)) && ((rs2 == 5'd0) -> (rdata2 == '0)))
        else $error("regFile: x0 read back nonzero");

endmodule

`default_nettype wire

// ==== design/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "singleCpu_params.svh"

module aluUnit (
    ctrlIf.alu               ctrl,
    input  logic [`XLEN-1:0] src1,
    input  logic [`XLEN-1:0] src2,
    input  logic [`XLEN-1:0] imm,
    output logic [`XLEN-1:0] result,
    output logic             zero
);
    import singleCpuPkg::*;

    logic [`XLEN-1:0] opB;
    logic             lessThan;

    assign opB      = ctrl.aluSrc ? imm : src2;
    assign lessThan = $signed(src1) < $signed(opB);

    always_comb begin
        case (ctrl.aluOp)
            ADD:     result = src1 + opB;
            SUB:     result = src1 - opB;
            AND:     result = src1 & opB;
            OR:      result = src1 | opB;
            SLT:     result = {{(`XLEN-1){1'b0}}, lessThan}; // Signed compare
            default: result = src1 + opB;
        endcase
    end

    // Drives the beq decision
    assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== design/loadStoreUnit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "singleCpu_params.svh"

module loadStoreUnit (
    input  logic             CLK,
    ctrlIf.lsu               ctrl,
    input  logic [`XLEN-1:0] addr,
    input  logic [`XLEN-1:0] wdataIn,
    output logic [`XLEN-1:0] wbData,
    output logic             storeEn
);

    localparam int AW = $clog2(`DMEM_DEPTH);

    logic [`XLEN-1:0] dataMem [`DMEM_DEPTH];
    logic [AW-1:0]    wordIdx;
    logic [`XLEN-1:0] loadData;

    assign wordIdx = addr[AW+1:2]; // Word index, byte offset dropped
    assign storeEn = ctrl.memWrite;

    always_ff @(posedge CLK) begin
        if (storeEn) begin
            dataMem[wordIdx] <= wdataIn;
        end
    end

    assign loadData = dataMem[wordIdx];
    assign wbData   = ctrl.memToReg ? loadData : addr; // Load data or ALU result

    // Only whole words are supported
    assert property (@(posedge CLK) (ctrl.memWrite || ctrl.memToReg) |-> addr[1:0] == 2'b00)
        else $error("loadStoreUnit: unaligned access at %h", addr);

endmodule

`default_nettype wire

// ==== design/singleCpu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "singleCpu_params.svh"

module singleCpu (
    input  logic                  CLK,
    input  logic                  arstN,
    input  logic                  progWe,
    input  logic [5:0]            progAddr,
    input  logic [31:0]           progData,
    output logic [`XLEN-1:0]      pc,
    output singleCpuPkg::rvInstr_u instr,
    output logic                  wbEn,
    output logic [4:0]            wbAddr,
    output logic [`XLEN-1:0]      wbData,
    output logic                  storeEn,
    output logic [`XLEN-1:0]      storeAddr,
    output logic [`XLEN-1:0]      storeData
);

    ctrlIf ctrl ();

    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rdata1;
    logic [`XLEN-1:0] rdata2;
    logic [`XLEN-1:0] aluResult; // Also the load and store address
    logic             zero;

    pcUnit uPc (.CLK, .arstN, .ctrl(ctrl.pc), .imm, .zero, .pc);

    instrMem uImem (.CLK, .progWe, .progAddr, .progData, .pc, .instr);

    instrDecoder uDecoder (.arstN, .instr, .ctrl(ctrl.decoder), .imm);

    regFile uRegs (
        .CLK, .arstN, .ctrl(ctrl.regs),
        .rs1(instr.r.rs1), .rs2(instr.r.rs2), .rd(instr.r.rd),
        .wdata(wbData), .rdata1, .rdata2, .wbEn
    );

    aluUnit uAlu (.ctrl(ctrl.alu), .src1(rdata1), .src2(rdata2), .imm, .result(aluResult), .zero);

    loadStoreUnit uLsu (
        .CLK, .ctrl(ctrl.lsu), .addr(aluResult), .wdataIn(rdata2), .wbData, .storeEn
    );

    // Retirement trace
    assign wbAddr    = instr.r.rd;
    assign storeAddr = aluResult;
    assign storeData = rdata2;

endmodule

`default_nettype wire

// ==== test/singleCpuTb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "singleCpu_params.svh"

module singleCpuTb;
    import singleCpuPkg::*;

    localparam int PERIOD       = 10;
    localparam int PROG_LEN     = 56; // Random part before the self-loop
    localparam int RESET_CYCLES = 16;
    localparam int RUN_CYCLES   = 64;
    localparam logic [31:0] SELF_LOOP = 32'h0000_0063; // beq x0, x0, 0
    localparam logic [31:0] LOOP_PC   = 32'(PROG_LEN * 4);

    logic             CLK;
    logic             arstN;
    logic             progWe;
    logic [5:0]       progAddr;
    logic [31:0]      progData;
    logic [`XLEN-1:0] pc;
    rvInstr_u         instr;
    logic             wbEn;
    logic [4:0]       wbAddr;
    logic [`XLEN-1:0] wbData;
    logic             storeEn;
    logic [`XLEN-1:0] storeAddr;
    logic [`XLEN-1:0] storeData;

    logic [31:0]      seed;
    rvInstr_u         prog [PROG_LEN+1];
    logic [`XLEN-1:0] mRegs [32];          // Model register file
    logic [`XLEN-1:0] mMem [`DMEM_DEPTH];  // Model data memory
    logic [`XLEN-1:0] mPc;
    int               errCount;
    int               checkCount;
    int               loopCycles;

    singleCpu u_dut (
        .CLK, .arstN, .progWe, .progAddr, .progData, .pc, .instr,
        .wbEn, .wbAddr, .wbData, .storeEn, .storeAddr, .storeData
    );

    always #(PERIOD / 2) CLK = ~CLK;

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int randBelow(input int n);
        logic [31:0] r;
        r = nextRand();
        return int'(r[31:16]) % n; // Upper bits since the low LCG bits are weak
    endfunction

    task automatic checkWord(input string name, input logic [`XLEN-1:0] got,
                             input logic [`XLEN-1:0] exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkInstr(input string name, input rvInstr_u got, input rvInstr_u exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic buildProgram();
        logic [11:0] stored [$]; // Addresses certain to be written
        logic [11:0] imm;
        logic [12:0] bOff;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        skippable;
        int          skipLeft;
        int          kind;
        int          k;
        skipLeft = 0;
        for (int n = 0; n < PROG_LEN; n++) begin
            skippable = (skipLeft > 0); // A branch before may jump over this one
            if (skipLeft > 0) begin
                skipLeft--;
            end
            kind = randBelow(10);
            rd   = 5'(randBelow(16));
            rs1  = 5'(randBelow(16));
            rs2  = 5'(randBelow(16));
            imm  = 12'(randBelow(4096));
            if ((kind == 7 || kind == 8) && stored.size() == 0) begin
                kind = 3; // Nothing to load yet
            end
            case (kind)
                0, 1, 2: begin
                    case (randBelow(5))
                        0:       prog[n] = {7'b0000000, rs2, rs1, 3'b000, rd, OP};
                        1:       prog[n] = {7'b0100000, rs2, rs1, 3'b000, rd, OP}; // sub
                        2:       prog[n] = {7'b0000000, rs2, rs1, 3'b111, rd, OP};
                        3:       prog[n] = {7'b0000000, rs2, rs1, 3'b110, rd, OP};
                        default: prog[n] = {7'b0000000, rs2, rs1, 3'b010, rd, OP};
                    endcase
                end
                3, 4: prog[n] = {imm, rs1, 3'b000, rd, OP_IMM};
                5, 6: begin
                    imm     = {4'd0, 6'(randBelow(64)), 2'b00};
                    prog[n] = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], STORE};
                    if (!skippable) begin
                        stored.push_back(imm);
                    end
                end
                7, 8: begin
                    imm     = stored[randBelow(stored.size())];
                    prog[n] = {imm, 5'd0, 3'b010, rd, LOAD};
                end
                default: begin
                    k = 1 + randBelow(3);
                    if (n + k > PROG_LEN) begin
                        k = PROG_LEN - n; // Never past the self-loop
                    end
                    if (randBelow(2) == 0) begin
                        rs2 = rs1;
                    end
                    bOff    = 13'(k * 4);
                    prog[n] = {bOff[12], bOff[10:5], rs2, rs1, 3'b000, bOff[4:1], bOff[11],
                               BRANCH};
                    if (k - 1 > skipLeft) begin
                        skipLeft = k - 1;
                    end
                end
            endcase
        end
        prog[PROG_LEN] = SELF_LOOP;
    endtask

    task automatic checkResetState();
        checkWord("pc", pc, '0);
        checkBit("wbEn", wbEn, 1'b0);
        checkBit("storeEn", storeEn, 1'b0);
    endtask

    // Predict one retirement, compare, then advance the model
    task automatic stepModel();
        int               idx;
        logic [31:0]      w;
        logic [`XLEN-1:0] r1;
        logic [`XLEN-1:0] r2;
        logic [`XLEN-1:0] res;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] nextPc;
        logic             writes;
        logic             stores;
        idx    = int'(mPc >> 2);
        w      = prog[idx];
        r1     = mRegs[w[19:15]];
        r2     = mRegs[w[24:20]];
        res    = '0;
        addr   = '0;
        nextPc = mPc + 32'd4;
        writes = 1'b0;
        stores = 1'b0;
        case (w[6:0])
            OP: begin
                writes = 1'b1;
                case ({w[30], w[14:12]})
                    4'b1000: res = r1 - r2;
                    4'b0111: res = r1 & r2;
                    4'b0110: res = r1 | r2;
                    4'b0010: res = ($signed(r1) < $signed(r2)) ? 32'd1 : 32'd0;
                    default: res = r1 + r2;
                endcase
            end
            OP_IMM: begin
                writes = 1'b1;
                res    = r1 + {{20{w[31]}}, w[31:20]};
            end
            LOAD: begin
                writes = 1'b1;
                addr   = r1 + {{20{w[31]}}, w[31:20]};
                res    = mMem[addr[7:2]];
            end
            STORE: begin
                stores = 1'b1;
                addr   = r1 + {{20{w[31]}}, w[31:25], w[11:7]};
            end
            BRANCH: begin
                if (r1 == r2) begin
                    nextPc = mPc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            default: begin
            end
        endcase
        checkWord("pc", pc, mPc);
        checkInstr("instr", instr, prog[idx]);
        checkBit("wbEn", wbEn, writes && (w[11:7] != 5'd0)); // x0 is never written
        checkWord("wbAddr", {27'd0, wbAddr}, {27'd0, w[11:7]});
        if (writes && w[11:7] != 5'd0) begin
            checkWord("wbData", wbData, res);
            mRegs[w[11:7]] = res;
        end
        checkBit("storeEn", storeEn, stores);
        if (stores) begin
            checkWord("storeAddr", storeAddr, addr);
            checkWord("storeData", storeData, r2);
            mMem[addr[7:2]] = r2;
        end
        if (w == SELF_LOOP) begin
            loopCycles++;
        end
        mPc = nextPc;
    endtask

    task automatic reportTest(input string name, input int errBefore);
        if (errCount == errBefore) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, errCount - errBefore);
        end
    endtask

    // Watchdog sized from load, reset and run lengths
    initial begin
        #((PROG_LEN + 1 + RESET_CYCLES + RUN_CYCLES + 10) * PERIOD);
        $display("Run timed out before all tests finished");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int errBefore;
        CLK        = 1'b0;
        arstN      = 1'b0;
        progWe     = 1'b0;
        progAddr   = '0;
        progData   = '0;
        seed       = 32'h6570_f2e0;
        errCount   = 0;
        checkCount = 0;
        loopCycles = 0;
        mPc        = '0;
        for (int i = 0; i < 32; i++) begin
            mRegs[i] = '0;
        end
        buildProgram();

        // Program load followed by the reset hold
        errBefore = errCount;
        for (int i = 0; i <= PROG_LEN; i++) begin
            @(posedge CLK);
            progWe   <= 1'b1;
            progAddr <= 6'(i);
            progData <= prog[i];
            @(negedge CLK);
            checkResetState();
        end
        repeat (RESET_CYCLES) begin
            @(posedge CLK);
            progWe <= 1'b0;
            @(negedge CLK);
            checkResetState();
        end
        @(posedge CLK);
        arstN <= 1'b1;
        reportTest("reset and program load", errBefore);

        errBefore = errCount;
        repeat (RUN_CYCLES) begin
            @(negedge CLK); // Outputs are settled before the next edge retires
            stepModel();
        end
        reportTest("random program trace", errBefore);

        errBefore = errCount;
        if (loopCycles == 0 || pc != LOOP_PC) begin
            errCount++;
            $display("Program never settled in its closing self-loop");
        end
        reportTest("closing self-loop", errBefore);

        $display("Checks: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== singleCpu.f ====
+incdir+design
design/singleCpuPkg.sv
design/ctrlIf.sv
design/instrDecoder.sv
design/pcUnit.sv
design/instrMem.sv
design/regFile.sv
design/aluUnit.sv
design/loadStoreUnit.sv
design/singleCpu.sv
test/singleCpuTb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module singleCpuTb -f singleCpu.f -o singleCpuSim
	./obj_dir/singleCpuSim | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
